//--- rtl/ctrlPkg.sv
package ctrlPkg;

	typedef logic [31:0] instr_t;
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	typedef logic [2:0] memWidth_t;
	typedef logic [2:0] srcA_t;
	typedef logic [2:0] srcB_t;
	typedef logic [2:0] wbSel_t;

	// Major opcodes
	// Branch group follows the in-house encoding
	localparam opcode_t opcOp = 7'b0110011;
	localparam opcode_t opcOpImm = 7'b0010011;
	localparam opcode_t opcLoad = 7'b0000011;
	localparam opcode_t opcStore = 7'b0100011;
	localparam opcode_t opcBeq = 7'b1100011;
	localparam opcode_t opcJalrBranch = 7'b1100111; // jalr, bne, bge, blt
	localparam opcode_t opcLui = 7'b0110111;
	localparam opcode_t opcJal = 7'b1101111;

	// Memory access width codes shared by loads and stores
	localparam memWidth_t widthNone = 3'd0;
	localparam memWidth_t widthD = 3'd1;
	localparam memWidth_t widthW = 3'd2;
	localparam memWidth_t widthH = 3'd3;
	localparam memWidth_t widthB = 3'd4;
	localparam memWidth_t widthWu = 3'd5; // Loads only
	localparam memWidth_t widthHu = 3'd6;
	localparam memWidth_t widthBu = 3'd7;

	// Operand A mux
	localparam srcA_t srcAPc = 3'd0;
	localparam srcA_t srcARegA = 3'd1;

	// Operand B mux
	localparam srcB_t srcBRegB = 3'd0;
	localparam srcB_t srcBFour = 3'd1;
	localparam srcB_t srcBImm = 3'd2;
	localparam srcB_t srcBImmShift = 3'd3; // Branch and jump offset

	// Register file write-back mux
	localparam wbSel_t wbAluOut = 3'd0;
	localparam wbSel_t wbMemData = 3'd1;
	localparam wbSel_t wbShifter = 3'd3;
	localparam wbSel_t wbPcLink = 3'd7;

	typedef enum logic [2:0] {
		aluPass = 3'd0,
		aluAdd = 3'd1,
		aluSub = 3'd2,
		aluAnd = 3'd3,
		aluCmp = 3'd7
	} aluOp_t;

	typedef enum logic [1:0] {
		shiftLeft = 2'd0,
		shiftRightLogic = 2'd1,
		shiftRightArith = 2'd2
	} shiftOp_t;

	typedef enum logic [4:0] {
		opAdd, opSub, opAnd, opSlt,
		opAddi, opSlti,
		opSlli, opSrli, opSrai,
		opLoad, opStore,
		opBeq, opBne, opBge, opBlt,
		opLui, opJal, opJalr,
		opIllegal
	} instrOp_t;

	typedef enum logic [4:0] {
		stReset, stFetch, stDecode,
		stAluReg, stAluImm, stWriteback,
		stShift,
		stLoadAddr, stLoadMem1, stLoadMem2, stLoadWrite,
		stStoreAddr, stStoreWrite,
		stBranch,
		stLui1, stLui2,
		stJal1, stJal2,
		stJalr1, stJalr2
	} ctrlState_t;

	// Datapath control word for one cycle
	typedef struct packed {
		logic pcWrite;
		logic pcWriteCond;
		logic pcSrc; // 1 selects aluOut as next PC
		logic irWrite;
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic loadRegA;
		logic loadRegB;
		logic loadAluOut;
		logic loadMemData;
		aluOp_t aluOp;
		srcA_t srcA;
		srcB_t srcB;
		logic aluResultSel; // Less flag instead of ALU result
		wbSel_t wbSel;
		shiftOp_t shiftOp;
		memWidth_t loadWidth;
		memWidth_t storeWidth;
	} ctrlWord_t;

endpackage

//--- rtl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder #(
	parameter bit rv64 = 1'b1
) (
	input ctrlPkg::instr_t instr,
	output ctrlPkg::instrOp_t op,
	output ctrlPkg::memWidth_t memWidth
);

	ctrlPkg::opcode_t opcode;
	ctrlPkg::funct3_t funct3;
	ctrlPkg::funct7_t funct7;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	always_comb begin
		op = ctrlPkg::opIllegal;
		memWidth = ctrlPkg::widthNone;

		case (opcode)
			ctrlPkg::opcOp: begin
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: op = ctrlPkg::opAdd;
					{7'b0100000, 3'b000}: op = ctrlPkg::opSub;
					{7'b0000000, 3'b111}: op = ctrlPkg::opAnd;
					{7'b0000000, 3'b010}: op = ctrlPkg::opSlt;
					default: op = ctrlPkg::opIllegal;
				endcase
			end

			ctrlPkg::opcOpImm: begin
				// Shift amount reaches bit 25 on RV64, so only funct7[6:1] is checked
				case (funct3)
					3'b000: op = ctrlPkg::opAddi;
					3'b010: op = ctrlPkg::opSlti;
					3'b001: begin
						if (funct7[6:1] == 6'b000000) begin
							op = ctrlPkg::opSlli;
						end
					end
					3'b101: begin
						if (funct7[6:1] == 6'b000000) begin
							op = ctrlPkg::opSrli;
						end else if (funct7[6:1] == 6'b010000) begin
							op = ctrlPkg::opSrai;
						end
					end
					default: op = ctrlPkg::opIllegal;
				endcase
			end

			ctrlPkg::opcLoad: begin
				case (funct3)
					3'b000: memWidth = ctrlPkg::widthB;
					3'b001: memWidth = ctrlPkg::widthH;
					3'b010: memWidth = ctrlPkg::widthW;
					3'b011: memWidth = rv64 ? ctrlPkg::widthD : ctrlPkg::widthNone; // ld
					3'b100: memWidth = ctrlPkg::widthBu;
					3'b101: memWidth = ctrlPkg::widthHu;
					3'b110: memWidth = rv64 ? ctrlPkg::widthWu : ctrlPkg::widthNone; // lwu
					default: memWidth = ctrlPkg::widthNone;
				endcase
				op = (memWidth == ctrlPkg::widthNone) ? ctrlPkg::opIllegal : ctrlPkg::opLoad;
			end

			ctrlPkg::opcStore: begin
				// sd uses the standard funct3 011
				case (funct3)
					3'b000: memWidth = ctrlPkg::widthB;
					3'b001: memWidth = ctrlPkg::widthH;
					3'b010: memWidth = ctrlPkg::widthW;
					3'b011: memWidth = rv64 ? ctrlPkg::widthD : ctrlPkg::widthNone;
					default: memWidth = ctrlPkg::widthNone;
				endcase
				op = (memWidth == ctrlPkg::widthNone) ? ctrlPkg::opIllegal : ctrlPkg::opStore;
			end

			ctrlPkg::opcBeq: op = ctrlPkg::opBeq; // funct3 not checked

			ctrlPkg::opcJalrBranch: begin
				case (funct3)
					3'b000: op = ctrlPkg::opJalr;
					3'b001: op = ctrlPkg::opBne;
					3'b101: op = ctrlPkg::opBge;
					3'b100: op = ctrlPkg::opBlt;
					default: op = ctrlPkg::opIllegal;
				endcase
			end

			ctrlPkg::opcLui: op = ctrlPkg::opLui;
			ctrlPkg::opcJal: op = ctrlPkg::opJal;

			default: op = ctrlPkg::opIllegal;
		endcase
	end

endmodule

//--- rtl/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer (
	input logic rst, // Clock
	input logic clk, // Async active-high reset
	input ctrlPkg::instrOp_t op,
	input ctrlPkg::memWidth_t memWidth,
	output ctrlPkg::ctrlState_t state,
	output ctrlPkg::instrOp_t opReg,
	output ctrlPkg::memWidth_t widthReg
);

	ctrlPkg::ctrlState_t nextState;

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			state <= ctrlPkg::stReset;
			opReg <= ctrlPkg::opIllegal;
			widthReg <= ctrlPkg::widthNone;
		end else begin
			state <= nextState;
			// Hold the decoded instruction for the rest of its sequence
			if (state == ctrlPkg::stDecode) begin
				opReg <= op;
				widthReg <= memWidth;
			end
		end
	end

	always_comb begin
		nextState = ctrlPkg::stFetch;
		case (state)
			ctrlPkg::stReset: nextState = ctrlPkg::stFetch;
			ctrlPkg::stFetch: nextState = ctrlPkg::stDecode;

			ctrlPkg::stDecode: begin
				case (op)
					ctrlPkg::opAdd,
					ctrlPkg::opSub,
					ctrlPkg::opAnd,
					ctrlPkg::opSlt: nextState = ctrlPkg::stAluReg;
					ctrlPkg::opAddi,
					ctrlPkg::opSlti: nextState = ctrlPkg::stAluImm;
					ctrlPkg::opSlli,
					ctrlPkg::opSrli,
					ctrlPkg::opSrai: nextState = ctrlPkg::stShift;
					ctrlPkg::opLoad: nextState = ctrlPkg::stLoadAddr;
					ctrlPkg::opStore: nextState = ctrlPkg::stStoreAddr;
					ctrlPkg::opBeq,
					ctrlPkg::opBne,
					ctrlPkg::opBge,
					ctrlPkg::opBlt: nextState = ctrlPkg::stBranch;
					ctrlPkg::opLui: nextState = ctrlPkg::stLui1;
					ctrlPkg::opJal: nextState = ctrlPkg::stJal1;
					ctrlPkg::opJalr: nextState = ctrlPkg::stJalr1;
					default: nextState = ctrlPkg::stFetch; // Unknown encoding is dropped
				endcase
			end

			ctrlPkg::stAluReg,
			ctrlPkg::stAluImm: nextState = ctrlPkg::stWriteback;

			// Loads spend two cycles waiting on memory
			ctrlPkg::stLoadAddr: nextState = ctrlPkg::stLoadMem1;
			ctrlPkg::stLoadMem1: nextState = ctrlPkg::stLoadMem2;
			ctrlPkg::stLoadMem2: nextState = ctrlPkg::stLoadWrite;

			ctrlPkg::stStoreAddr: nextState = ctrlPkg::stStoreWrite;

			ctrlPkg::stLui1: nextState = ctrlPkg::stLui2;
			ctrlPkg::stJal1: nextState = ctrlPkg::stJal2;
			ctrlPkg::stJalr1: nextState = ctrlPkg::stJalr2;

			// Last state of every class goes back to fetch
			ctrlPkg::stWriteback,
			ctrlPkg::stShift,
			ctrlPkg::stLoadWrite,
			ctrlPkg::stStoreWrite,
			ctrlPkg::stBranch,
			ctrlPkg::stLui2,
			ctrlPkg::stJal2,
			ctrlPkg::stJalr2: nextState = ctrlPkg::stFetch;

			default: nextState = ctrlPkg::stFetch;
		endcase
	end

endmodule

//--- rtl/controlWordTable.sv
`timescale 1ns/1ps

module controlWordTable (
	input ctrlPkg::ctrlState_t state,
	input ctrlPkg::instrOp_t opReg,
	input ctrlPkg::memWidth_t widthReg,
	input bit aluZero,
	input bit aluLess,
	output ctrlPkg::ctrlWord_t ctrl
);

	logic branchTaken;
	logic isCompare; // slt and slti take the less flag

	always_comb begin
		case (opReg)
			ctrlPkg::opBeq: branchTaken = aluZero;
			ctrlPkg::opBne: branchTaken = !aluZero;
			ctrlPkg::opBlt: branchTaken = aluLess;
			ctrlPkg::opBge: branchTaken = !aluLess;
			default: branchTaken = 1'b0;
		endcase
	end

	assign isCompare = (opReg == ctrlPkg::opSlt) || (opReg == ctrlPkg::opSlti);

	always_comb begin
		ctrl = '0;

		case (state)
			ctrlPkg::stFetch: begin
				ctrl.irWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.pcWrite = 1'b1; // PC + 4
				ctrl.aluOp = ctrlPkg::aluAdd;
				ctrl.srcA = ctrlPkg::srcAPc;
				ctrl.srcB = ctrlPkg::srcBFour;
			end

			ctrlPkg::stDecode: begin
				// Read registers and precompute the branch target
				ctrl.loadRegA = 1'b1;
				ctrl.loadRegB = 1'b1;
				ctrl.loadAluOut = 1'b1;
				ctrl.aluOp = ctrlPkg::aluAdd;
				ctrl.srcA = ctrlPkg::srcAPc;
				ctrl.srcB = ctrlPkg::srcBImmShift;
			end

			ctrlPkg::stAluReg: begin
				ctrl.srcA = ctrlPkg::srcARegA;
				ctrl.srcB = ctrlPkg::srcBRegB;
				ctrl.loadAluOut = 1'b1;
				ctrl.aluResultSel = isCompare;
				case (opReg)
					ctrlPkg::opSub: ctrl.aluOp = ctrlPkg::aluSub;
					ctrlPkg::opAnd: ctrl.aluOp = ctrlPkg::aluAnd;
					ctrlPkg::opSlt: ctrl.aluOp = ctrlPkg::aluPass;
					default: ctrl.aluOp = ctrlPkg::aluAdd;
				endcase
			end

			ctrlPkg::stAluImm: begin
				ctrl.srcA = ctrlPkg::srcARegA;
				ctrl.srcB = ctrlPkg::srcBImm;
				ctrl.loadAluOut = 1'b1;
				ctrl.aluResultSel = isCompare;
				ctrl.aluOp = isCompare ? ctrlPkg::aluPass : ctrlPkg::aluAdd;
			end

			ctrlPkg::stWriteback: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = ctrlPkg::wbAluOut;
			end

			ctrlPkg::stShift: begin
				// Shifter result goes straight to the register file
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = ctrlPkg::wbShifter;
				case (opReg)
					ctrlPkg::opSrli: ctrl.shiftOp = ctrlPkg::shiftRightLogic;
					ctrlPkg::opSrai: ctrl.shiftOp = ctrlPkg::shiftRightArith;
					default: ctrl.shiftOp = ctrlPkg::shiftLeft;
				endcase
			end

			ctrlPkg::stLoadAddr,
			ctrlPkg::stStoreAddr: begin
				ctrl.srcA = ctrlPkg::srcARegA;
				ctrl.srcB = ctrlPkg::srcBImm;
				ctrl.aluOp = ctrlPkg::aluAdd;
				ctrl.loadAluOut = 1'b1;
				if (state == ctrlPkg::stLoadAddr) begin
					ctrl.loadWidth = widthReg;
				end else begin
					ctrl.storeWidth = widthReg;
				end
			end

			ctrlPkg::stLoadMem1,
			ctrlPkg::stLoadMem2: begin
				ctrl.memRead = 1'b1;
				ctrl.loadMemData = 1'b1;
				ctrl.loadWidth = widthReg;
			end

			ctrlPkg::stLoadWrite: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = ctrlPkg::wbMemData;
				ctrl.loadWidth = widthReg;
			end

			ctrlPkg::stStoreWrite: begin
				ctrl.memWrite = 1'b1;
				ctrl.storeWidth = widthReg;
			end

			ctrlPkg::stBranch: begin
				ctrl.srcA = ctrlPkg::srcARegA;
				ctrl.srcB = ctrlPkg::srcBRegB;
				ctrl.aluOp = (opReg == ctrlPkg::opBeq || opReg == ctrlPkg::opBne) ?
					ctrlPkg::aluSub : ctrlPkg::aluCmp;
				ctrl.pcWrite = branchTaken;
				ctrl.pcWriteCond = branchTaken;
				ctrl.pcSrc = branchTaken; // Target already sits in aluOut
			end

			ctrlPkg::stLui1: begin
				ctrl.srcB = ctrlPkg::srcBImm;
				ctrl.aluOp = ctrlPkg::aluPass;
				ctrl.loadAluOut = 1'b1;
			end

			ctrlPkg::stLui2: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = ctrlPkg::wbAluOut;
			end

			// Link register written first with the jump target latched alongside
			ctrlPkg::stJal1,
			ctrlPkg::stJalr1: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = ctrlPkg::wbPcLink;
				ctrl.aluOp = ctrlPkg::aluAdd;
				ctrl.loadAluOut = 1'b1;
				if (state == ctrlPkg::stJal1) begin
					ctrl.srcA = ctrlPkg::srcAPc;
					ctrl.srcB = ctrlPkg::srcBImmShift;
				end else begin
					ctrl.srcA = ctrlPkg::srcARegA;
					ctrl.srcB = ctrlPkg::srcBImm;
				end
			end

			ctrlPkg::stJal2,
			ctrlPkg::stJalr2: begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSrc = 1'b1;
			end

			default: ctrl = '0; // stReset keeps every bit low
		endcase
	end

endmodule

//--- rtl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit #(
	parameter bit rv64 = 1'b1 // Enables ld, lwu and sd
) (
	input logic rst, // Clock
	input logic clk, // Async active-high reset
	input ctrlPkg::instr_t instr,
	input logic aluZero,
	input logic aluLess,
	output ctrlPkg::ctrlWord_t ctrl
);

	ctrlPkg::instrOp_t decOp;
	ctrlPkg::memWidth_t decWidth;
	ctrlPkg::ctrlState_t state;
	ctrlPkg::instrOp_t opReg;
	ctrlPkg::memWidth_t widthReg;

	instrDecoder #(
		.rv64(rv64)
	) u_instrDecoder (
		.instr(instr),
		.op(decOp),
		.memWidth(decWidth)
	);

	controlSequencer u_controlSequencer (
		.rst(rst),
		.clk(clk),
		.op(decOp),
		.memWidth(decWidth),
		.state(state),
		.opReg(opReg),
		.widthReg(widthReg)
	);

	controlWordTable u_controlWordTable (
		.state(state),
		.opReg(opReg),
		.widthReg(widthReg),
		.aluZero(aluZero),
		.aluLess(aluLess),
		.ctrl(ctrl)
	);

endmodule

//--- bench/tbStimulus.svh
// Included inside controlUnitTb and uses its signals and counters

function automatic bit randomBit();
	bit b;
	b = lfsr[0];
	lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1); // One Galois step per bit
	return b;
endfunction

// Fixed registers rd x5, rs1 x6 and rs2 x7
// S and B immediates ride in the same bits
function automatic ctrlPkg::instr_t encR(input logic [6:0] funct7, input logic [2:0] funct3,
	input logic [6:0] opcode);
	return {funct7, 5'd7, 5'd6, funct3, 5'd5, opcode};
endfunction

function automatic ctrlPkg::instr_t encI(input logic [11:0] imm, input logic [2:0] funct3,
	input logic [6:0] opcode);
	return {imm, 5'd6, funct3, 5'd5, opcode};
endfunction

// Runs one instruction from its fetch to the next fetch
task automatic runInstr(input ctrlPkg::instr_t word, input int kind, input logic [2:0] code,
	input string name);
	int startErrors;
	int waitCount;
	int n;
	int cycles;
	int regAt;
	int regCount;
	int memWrCount;
	int memDataCount;

	startErrors = errors;
	cycles = 4; // Alu and lui
	regAt = 3;
	case (kind)
		kindShift: begin
			cycles = 3;
			regAt = 2;
		end
		kindLoad: begin
			cycles = 6;
			regAt = 5;
		end
		kindStore: regAt = -1;
		kindBranch: begin
			cycles = 3;
			regAt = -1;
		end
		kindJump: regAt = 2;
		kindIllegal: begin
			cycles = 2;
			regAt = -1;
		end
		default: ;
	endcase

	waitCount = 0;
	while (!ctrl.irWrite && waitCount < 20) begin
		nextCycle();
		waitCount++;
	end
	if (!ctrl.irWrite) begin
		$display("Timeout: irWrite never came before %s", name);
		errors++;
		finishTest(startErrors, name);
		return;
	end
	expectTrue(ctrl.pcWrite && ctrl.memRead && ctrl.aluOp == ctrlPkg::aluAdd,
		{name, ": fetch control word wrong"});

	nextInstr = word;
	n = 1;
	regCount = 0;
	memWrCount = 0;
	memDataCount = 0;
	waitCount = 0;
	nextCycle();
	while (!ctrl.irWrite && waitCount < 20) begin
		if (n == 1) begin
			expectTrue(ctrl.loadRegA && ctrl.loadRegB && ctrl.loadAluOut,
				{name, ": decode control word wrong"});
		end
		if (ctrl.regWrite) begin
			regCount++;
			expectTrue(n == regAt, $sformatf("%s: regWrite in cycle %0d", name, n));
			if (kind == kindLoad) begin
				expectTrue(ctrl.loadWidth == code, {name, ": loadWidth wrong at write"});
			end
		end
		if (ctrl.memWrite) begin
			memWrCount++;
			expectTrue(n == 3 && ctrl.storeWidth == code, {name, ": memWrite cycle or width"});
		end
		if (ctrl.loadMemData) begin
			memDataCount++;
			expectTrue((n == 3 || n == 4) && ctrl.loadWidth == code,
				{name, ": loadMemData cycle or width"});
		end
		if (n == 2) begin
			case (kind)
				kindAlu: expectTrue(ctrl.aluOp == code &&
					ctrl.aluResultSel == (code == ctrlPkg::aluPass), {name, ": aluOp wrong"});
				kindShift: expectTrue(ctrl.shiftOp == code[1:0], {name, ": shiftOp wrong"});
				kindBranch: expectTrue(ctrl.pcWrite == branchTaken(code) &&
					ctrl.pcWriteCond == branchTaken(code) && ctrl.pcSrc == branchTaken(code),
					$sformatf("%s: pcWrite %0b with zero %0b less %0b",
					name, ctrl.pcWrite, aluZero, aluLess));
				kindJump: expectTrue(!ctrl.pcWrite, {name, ": pcWrite too early"});
				default: ;
			endcase
		end
		if (n == 3 && kind == kindJump) begin
			expectTrue(ctrl.pcWrite && ctrl.pcSrc, {name, ": no jump in second state"});
		end
		n++;
		waitCount++;
		nextCycle();
	end
	if (!ctrl.irWrite) begin
		$display("Timeout: irWrite never came back after %s", name);
		errors++;
	end

	expectTrue(n == cycles, $sformatf("%s: took %0d cycles, expected %0d", name, n, cycles));
	expectTrue(regCount == (regAt >= 0 ? 1 : 0), {name, ": regWrite count wrong"});
	expectTrue(memWrCount == (kind == kindStore ? 1 : 0), {name, ": memWrite count wrong"});
	expectTrue(memDataCount == (kind == kindLoad ? 2 : 0), {name, ": loadMemData count wrong"});
	finishTest(startErrors, name);
endtask

task automatic runAll();
	runInstr(encR(7'b0000000, 3'b000, 7'b0110011), kindAlu, ctrlPkg::aluAdd, "add");
	runInstr(encR(7'b0100000, 3'b000, 7'b0110011), kindAlu, ctrlPkg::aluSub, "sub");
	runInstr(encR(7'b0000000, 3'b111, 7'b0110011), kindAlu, ctrlPkg::aluAnd, "and");
	runInstr(encR(7'b0000000, 3'b010, 7'b0110011), kindAlu, ctrlPkg::aluPass, "slt");
	runInstr(encI(12'd17, 3'b000, 7'b0010011), kindAlu, ctrlPkg::aluAdd, "addi");
	runInstr(32'h00000013, kindAlu, ctrlPkg::aluAdd, "nop");
	runInstr(encI(12'hffb, 3'b010, 7'b0010011), kindAlu, ctrlPkg::aluPass, "slti");
	runInstr(encI(12'h003, 3'b001, 7'b0010011), kindShift, ctrlPkg::shiftLeft, "slli");
	runInstr(encI(12'h021, 3'b001, 7'b0010011), kindShift, ctrlPkg::shiftLeft, "slli64");
	runInstr(encI(12'h003, 3'b101, 7'b0010011), kindShift, ctrlPkg::shiftRightLogic, "srli");
	runInstr(encI(12'h403, 3'b101, 7'b0010011), kindShift, ctrlPkg::shiftRightArith, "srai");
	runInstr(encI(12'd8, 3'b000, 7'b0000011), kindLoad, 3'd4, "lb");
	runInstr(encI(12'd8, 3'b001, 7'b0000011), kindLoad, 3'd3, "lh");
	runInstr(encI(12'd8, 3'b010, 7'b0000011), kindLoad, 3'd2, "lw");
	runInstr(encI(12'd8, 3'b011, 7'b0000011), kindLoad, 3'd1, "ld");
	runInstr(encI(12'd8, 3'b100, 7'b0000011), kindLoad, 3'd7, "lbu");
	runInstr(encI(12'd8, 3'b101, 7'b0000011), kindLoad, 3'd6, "lhu");
	runInstr(encI(12'd8, 3'b110, 7'b0000011), kindLoad, 3'd5, "lwu");
	runInstr(encR(7'd0, 3'b000, 7'b0100011), kindStore, 3'd4, "sb");
	runInstr(encR(7'd0, 3'b001, 7'b0100011), kindStore, 3'd3, "sh");
	runInstr(encR(7'd1, 3'b010, 7'b0100011), kindStore, 3'd2, "sw");
	runInstr(encR(7'd1, 3'b011, 7'b0100011), kindStore, 3'd1, "sd");
	repeat (4) runInstr(encR(7'd0, 3'b000, 7'b1100011), kindBranch, 3'd0, "beq");
	repeat (4) runInstr(encR(7'd0, 3'b001, 7'b1100111), kindBranch, 3'd1, "bne");
	repeat (4) runInstr(encR(7'd0, 3'b100, 7'b1100111), kindBranch, 3'd2, "blt");
	repeat (4) runInstr(encR(7'd0, 3'b101, 7'b1100111), kindBranch, 3'd3, "bge");
	runInstr(encI(12'h123, 3'b100, 7'b0110111), kindLui, 3'd0, "lui");
	runInstr(encI(12'h010, 3'b000, 7'b1101111), kindJump, 3'd0, "jal");
	runInstr(encI(12'h004, 3'b000, 7'b1100111), kindJump, 3'd0, "jalr");
	// Unknown opcode and funct combinations
	runInstr(32'h00000000, kindIllegal, 3'd0, "opcode0");
	runInstr(encR(7'b0000001, 3'b000, 7'b0110011), kindIllegal, 3'd0, "mul");
	runInstr(encI(12'd8, 3'b111, 7'b0000011), kindIllegal, 3'd0, "load111");
	runInstr(encR(7'd0, 3'b100, 7'b0100011), kindIllegal, 3'd0, "store100");
	runInstr(encR(7'd0, 3'b010, 7'b1100111), kindIllegal, 3'd0, "branch010");
	runInstr(encI(12'h443, 3'b101, 7'b0010011), kindIllegal, 3'd0, "shiftbad");
endtask

//--- bench/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;

	// Instruction classes with their own latency and flag pattern
	localparam int kindAlu = 0;
	localparam int kindShift = 1;
	localparam int kindLoad = 2;
	localparam int kindStore = 3;
	localparam int kindBranch = 4;
	localparam int kindLui = 5;
	localparam int kindJump = 6;
	localparam int kindIllegal = 7;

	logic rst; // Clock
	logic clk; // Reset
	ctrlPkg::instr_t instr;
	ctrlPkg::instr_t nextInstr; // Applied on the next falling edge
	logic aluZero;
	logic aluLess;
	ctrlPkg::ctrlWord_t ctrl;
	logic [31:0] lfsr;
	int errors;
	int testsRun;
	int testsFailed;

	controlUnit #(
		.rv64(1'b1)
	) u_controlUnit (
		.rst(rst),
		.clk(clk),
		.instr(instr),
		.aluZero(aluZero),
		.aluLess(aluLess),
		.ctrl(ctrl)
	);

	always #5 rst = ~rst;

	`include "tbStimulus.svh"

	task automatic expectTrue(input bit cond, input string msg);
		assert (cond) else begin
			$display("FAILED %0t ns: %s", $time, msg);
			errors++;
		end
	endtask

	// Inputs move on the falling edge and ctrl is read 1 ns before the rising edge
	task automatic nextCycle();
		@(negedge rst);
		instr = nextInstr;
		aluZero = randomBit();
		aluLess = randomBit();
		#4;
	endtask

	// Branch rule from the flags of the current cycle
	function automatic bit branchTaken(input logic [2:0] code);
		case (code)
			3'd0: return aluZero; // beq
			3'd1: return !aluZero; // bne
			3'd2: return aluLess; // blt
			default: return !aluLess; // bge
		endcase
	endfunction

	task automatic finishTest(input int startErrors, input string name);
		testsRun++;
		if (errors == startErrors) begin
			$display("%-10s ok", name);
		end else begin
			testsFailed++;
			$display("%-10s had errors", name);
		end
	endtask

	initial begin
		rst = 1'b0;
		clk = 1'b1;
		instr = '0;
		nextInstr = '0;
		aluZero = 1'b0;
		aluLess = 1'b0;
		lfsr = 32'ha4704f9c;
		errors = 0;
		testsRun = 0;
		testsFailed = 0;

		#4;
		expectTrue(ctrl == '0, "control word not zero in first reset cycle");
		@(negedge rst);
		#4;
		expectTrue(ctrl == '0, "control word not zero in second reset cycle");
		@(negedge rst);
		clk = 1'b0; // Release after two cycles
		#4;
		expectTrue(ctrl == '0, "control word not zero in the idle cycle after reset");
		nextCycle();
		expectTrue(ctrl.irWrite, "irWrite not high in the first fetch after reset");
		finishTest(0, "reset");

		runAll();

		$display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+bench
rtl/ctrlPkg.sv
rtl/instrDecoder.sv
rtl/controlSequencer.sv
rtl/controlWordTable.sv
rtl/controlUnit.sv
bench/controlUnitTb.sv
